//--- Bender.yml
package:
  name: uart_cmd_bridge

sources:
  - files:
      - verilog/uart_cmd_pkg.sv
      - verilog/cmd_arbiter.sv
      - verilog/cmd_sequencer.sv
      - verilog/uart_tx_frame.sv
      - verilog/uart_rx_frame.sv
      - verilog/uart_cmd_bridge.sv
  - target: test
    files:
      - dv/uart_cmd_bridge_tb.sv

//--- build.f
verilog/uart_cmd_pkg.sv
verilog/cmd_arbiter.sv
verilog/cmd_sequencer.sv
verilog/uart_tx_frame.sv
verilog/uart_rx_frame.sv
verilog/uart_cmd_bridge.sv
dv/uart_cmd_bridge_tb.sv

//--- dv/uart_cmd_bridge_tb.sv
module uart_cmd_bridge_tb;

  localparam int NUM_PORTS  = 2;
  localparam int BAUD_DIV   = 8;
  localparam int GAP_CYCLES = 12;
  localparam int RX_TIMEOUT = 400;
  localparam int FALL_LIMIT = 100 * BAUD_DIV; // longest wait for a start bit on tx.
  localparam int DONE_LIMIT = 4 * RX_TIMEOUT;

  logic                 clk;
  logic                 rst_n;
  uart_cmd_pkg::cmd_t   cmd [NUM_PORTS];
  logic [NUM_PORTS-1:0] cmd_vld;
  logic [NUM_PORTS-1:0] cmd_rdy;
  logic [NUM_PORTS-1:0] read_vld;
  logic [NUM_PORTS-1:0] read_err;
  uart_cmd_pkg::byte_t  read_data [NUM_PORTS];
  logic                 rx;
  logic                 tx;

  int                  t_port [$];
  uart_cmd_pkg::cmd_t  t_cmd [$];
  uart_cmd_pkg::byte_t t_reply [$];
  int                  t_mode [$];        // 0 normal reply, 1 flipped parity, 2 no reply.
  uart_cmd_pkg::byte_t t_exp_data [$];
  logic                t_exp_err [$];
  logic                t_pair [$];

  int                  vld_cnt [NUM_PORTS] = '{default: 0};
  int                  exp_cnt [NUM_PORTS] = '{default: 0};
  uart_cmd_pkg::byte_t got_data [NUM_PORTS];
  logic                got_err [NUM_PORTS];
  int                  last_port = NUM_PORTS - 1;

  uart_cmd_bridge #(
    .NUM_PORTS  (NUM_PORTS),
    .BAUD_DIV   (BAUD_DIV),
    .GAP_CYCLES (GAP_CYCLES),
    .RX_TIMEOUT (RX_TIMEOUT)
  ) i_uart_cmd_bridge (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_vld  (read_vld),
    .read_err  (read_err),
    .read_data (read_data),
    .rx        (rx),
    .tx        (tx)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #50 clk = ~clk;
  end

  // results are latched with non-blocking writes so the main process sees them a cycle later.
  always @(posedge clk)
  begin
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (read_vld[p] === 1'b1)
      begin
        vld_cnt[p]  <= vld_cnt[p] + 1;
        got_data[p] <= read_data[p];
        got_err[p]  <= read_err[p];
      end
    end
  end

  task automatic report_failure();
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare_byte(input string name, input uart_cmd_pkg::byte_t exp,
                              input uart_cmd_pkg::byte_t act);
    if (act !== exp)
    begin
      $display("ERROR time %0t: %s expected %02h got %02h", $time, name, exp, act);
      report_failure();
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("ERROR time %0t: %s expected %b got %b", $time, name, exp, act);
      report_failure();
    end
  endtask

  // odd parity: the bit is set when the data holds an even number of ones.
  function automatic logic parity_for(input uart_cmd_pkg::byte_t data);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++)
      ones += data[i];
    return (ones % 2) == 0;
  endfunction

  task automatic load_trace();
    int    fd;
    string line;
    int    port, cmd_v, reply, mode, exp_d, exp_e, pair;
    fd = $fopen("dv/uart_cmd_trace.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the trace file dv/uart_cmd_trace.txt");
      report_failure();
    end
    while ($fgets(line, fd) != 0)
    begin
      if (line.len() > 0 && line[0] != "#" &&
          $sscanf(line, "%d %h %h %d %h %d %d", port, cmd_v, reply, mode, exp_d, exp_e,
                  pair) == 7)
      begin
        t_port.push_back(port);
        t_cmd.push_back(uart_cmd_pkg::cmd_t'(cmd_v));
        t_reply.push_back(uart_cmd_pkg::byte_t'(reply));
        t_mode.push_back(mode);
        t_exp_data.push_back(uart_cmd_pkg::byte_t'(exp_d));
        t_exp_err.push_back(exp_e[0]);
        t_pair.push_back(pair[0]);
      end
    end
    $fclose(fd);
    if (t_port.size() == 0)
    begin
      $display("the trace file holds no commands");
      report_failure();
    end
  endtask

  task automatic check_reset_state();
    compare_bit("tx", 1'b1, tx);
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      compare_bit("cmd_rdy", 1'b1, cmd_rdy[p]);
      compare_bit("read_vld", 1'b0, read_vld[p]);
    end
  endtask

  // samples every bit of one tx frame at its middle.
  task automatic decode_tx_frame(output uart_cmd_pkg::byte_t data);
    logic seen;
    seen = 1'b0;
    for (int n = 0; n < FALL_LIMIT && !seen; n++)
    begin
      @(posedge clk);
      seen = (tx === 1'b0);
    end
    if (!seen)
    begin
      $display("timeout: no start bit on tx within %0d cycles", FALL_LIMIT);
      report_failure();
    end
    repeat (BAUD_DIV / 2) @(posedge clk);
    compare_bit("tx start bit", 1'b0, tx);
    for (int i = 0; i < 8; i++)
    begin
      repeat (BAUD_DIV) @(posedge clk);
      data[i] = tx;
    end
    repeat (BAUD_DIV) @(posedge clk);
    compare_bit("tx parity bit", parity_for(data), tx);
    repeat (BAUD_DIV) @(posedge clk);
    compare_bit("tx stop bit", 1'b1, tx);
  endtask

  task automatic send_reply(input uart_cmd_pkg::byte_t data, input logic flip);
    logic [10:0] bits;
    bits = {1'b1, parity_for(data) ^ flip, data, 1'b0};
    repeat (2 * BAUD_DIV) @(posedge clk); // the bridge is listening by then.
    for (int i = 0; i < 11; i++)
    begin
      rx <= bits[i];
      repeat (BAUD_DIV) @(posedge clk);
    end
    rx <= 1'b1;
  endtask

  task automatic wait_cmd_rdy(input int p);
    logic seen;
    seen = 1'b0;
    for (int n = 0; n < DONE_LIMIT && !seen; n++)
    begin
      @(posedge clk);
      seen = (cmd_rdy[p] === 1'b1);
    end
    if (!seen)
    begin
      $display("timeout: port %0d never became ready after its command", p);
      report_failure();
    end
  endtask

  task automatic present_commands(input int a, input int b);
    @(posedge clk);
    compare_bit("cmd_rdy", 1'b1, cmd_rdy[t_port[a]]);
    cmd[t_port[a]]     <= t_cmd[a];
    cmd_vld[t_port[a]] <= 1'b1;
    if (b >= 0)
    begin
      compare_bit("cmd_rdy", 1'b1, cmd_rdy[t_port[b]]);
      cmd[t_port[b]]     <= t_cmd[b];
      cmd_vld[t_port[b]] <= 1'b1;
    end
    @(posedge clk);
    cmd_vld <= '0;
  endtask

  // other is the port whose command waits behind this one, or -1.
  task automatic run_command(input int idx, input int other);
    int                  p;
    logic                is_read;
    uart_cmd_pkg::byte_t lo;
    uart_cmd_pkg::byte_t hi;
    p       = t_port[idx];
    is_read = !t_cmd[idx][15];
    decode_tx_frame(lo);
    compare_bit("cmd_rdy", 1'b0, cmd_rdy[p]);
    if (other >= 0)
      compare_bit("cmd_rdy", 1'b0, cmd_rdy[other]);
    compare_byte("tx low byte", t_cmd[idx][7:0], lo);
    decode_tx_frame(hi);
    compare_byte("tx high byte", t_cmd[idx][15:8], hi);
    if (is_read)
    begin
      exp_cnt[p]++;
      if (t_mode[idx] != 2)
        send_reply(t_reply[idx], t_mode[idx] == 1);
    end
    wait_cmd_rdy(p);
    @(posedge clk);
    if (other >= 0)
      compare_bit("cmd_rdy", 1'b0, cmd_rdy[other]);
    for (int q = 0; q < NUM_PORTS; q++)
    begin
      if (vld_cnt[q] != exp_cnt[q])
      begin
        $display("port %0d saw %0d read results where %0d were due", q, vld_cnt[q], exp_cnt[q]);
        report_failure();
      end
    end
    if (is_read)
    begin
      compare_byte("read_data", t_exp_data[idx], got_data[p]);
      compare_bit("read_err", t_exp_err[idx], got_err[p]);
    end
    last_port = p;
  endtask

  initial
  begin
    int          i;
    int          a;
    int          b;
    int          first;
    int unsigned seed_val;
    logic        counts_ok;
    rst_n    = 1'b0;
    cmd_vld  = '0;
    cmd[0]   = '0;
    cmd[1]   = '0;
    rx       = 1'b1;
    seed_val = $urandom(3);
    load_trace();
    repeat (2)
    begin
      @(negedge clk);
      check_reset_state();                  // outputs are settled halfway through the cycle.
    end
    @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_reset_state();
    i = 0;
    while (i < t_port.size())
    begin
      repeat ($urandom % 4) @(posedge clk);
      if (t_pair[i] && i + 1 < t_port.size())
      begin
        first = (last_port + 1) % NUM_PORTS; // round robin starts after the last winner.
        a     = (t_port[i] == first) ? i : i + 1;
        b     = (a == i) ? i + 1 : i;
        present_commands(a, b);
        run_command(a, t_port[b]);
        run_command(b, -1);
        i += 2;
      end
      else
      begin
        present_commands(i, -1);
        run_command(i, -1);
        i++;
      end
    end
    repeat (4) @(posedge clk);
    counts_ok = 1'b1;
    for (int q = 0; q < NUM_PORTS; q++)
      counts_ok &= (vld_cnt[q] == exp_cnt[q]);
    if (counts_ok)
    begin
      $display("RESULT: PASS");
      $finish;
    end
    else
    begin
      $display("a read result arrived after the last command finished");
      report_failure();
    end
  end

endmodule

//--- dv/uart_cmd_trace.txt
# port cmd reply mode exp_data exp_err with_next
# mode: 0 normal reply, 1 reply with flipped parity, 2 no reply; with_next 1 pairs a line
# with the next one in the same cycle
0 8a3c 00 0 00 0 1
1 1200 5e 0 5e 0 0
0 0700 c3 0 c3 0 0
1 ff81 00 0 00 0 0
1 2100 a5 1 a5 1 0
0 3400 00 2 00 1 0
0 4600 99 0 99 0 1
1 e6f0 00 0 00 0 0
0 7f00 01 1 01 1 0
1 0100 80 0 80 0 0
0 9b00 00 0 00 0 0
1 5a00 ff 0 ff 0 0

//--- verilog/cmd_arbiter.sv
module cmd_arbiter #(
  parameter  int NUM_PORTS = 2,
  localparam int PORT_W    = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  uart_cmd_pkg::cmd_t   cmd [NUM_PORTS],
  input  logic [NUM_PORTS-1:0] cmd_vld,
  output logic [NUM_PORTS-1:0] cmd_rdy,
  output logic [NUM_PORTS-1:0] read_vld,
  output uart_cmd_pkg::byte_t  read_data [NUM_PORTS],
  output logic [NUM_PORTS-1:0] read_err,
  input  logic                 seq_busy,
  input  logic                 seq_done,
  input  uart_cmd_pkg::byte_t  seq_rd_data,
  input  logic                 seq_rd_err,
  output logic                 seq_start,
  output uart_cmd_pkg::cmd_t   seq_cmd,
  output logic [PORT_W-1:0]    seq_port
);

  uart_cmd_pkg::cmd_t   pend_cmd [NUM_PORTS];
  logic [NUM_PORTS-1:0] pend_vld;
  logic [NUM_PORTS-1:0] issued;
  logic [NUM_PORTS-1:0] waiting;
  logic [PORT_W-1:0]    last_port;
  logic [PORT_W-1:0]    pick;
  logic                 pick_vld;
  logic                 grant;
  int                   rr_idx;

  assign cmd_rdy = ~pend_vld;             // a slot stays taken until its command is done.
  assign waiting = pend_vld & ~issued;
  assign grant   = pick_vld && (issued == '0) && !seq_busy;

  // search starts just after the last winner.
  always_comb
  begin
    pick     = last_port;
    pick_vld = 1'b0;
    rr_idx   = 0;
    for (int i = 1; i <= NUM_PORTS; i++)
    begin
      rr_idx = (int'(last_port) + i) % NUM_PORTS;
      if (!pick_vld && waiting[rr_idx])
      begin
        pick     = PORT_W'(rr_idx);
        pick_vld = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pend_vld  <= '0;
      issued    <= '0;
      last_port <= PORT_W'(NUM_PORTS - 1); // so that port 0 wins first.
      seq_start <= 1'b0;
      seq_port  <= '0;
      read_vld  <= '0;
      read_err  <= '0;
    end
    else
    begin
      seq_start <= grant;
      read_vld  <= '0;
      pend_vld  <= pend_vld | (cmd_vld & cmd_rdy);
      if (grant)
      begin
        issued[pick] <= 1'b1;
        last_port    <= pick;
        seq_port     <= pick;
      end
      if (seq_done)
      begin
        pend_vld[seq_port] <= 1'b0;
        issued[seq_port]   <= 1'b0;
        read_vld[seq_port] <= ~pend_cmd[seq_port][uart_cmd_pkg::CMD_RW_BIT]; // reads only.
        read_err[seq_port] <= seq_rd_err;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (cmd_vld[p] && cmd_rdy[p])
        pend_cmd[p] <= cmd[p];
    end
    if (grant)
      seq_cmd <= pend_cmd[pick];
    if (seq_done)
      read_data[seq_port] <= seq_rd_data;
  end

endmodule

//--- verilog/cmd_sequencer.sv
module cmd_sequencer #(
  parameter int GAP_CYCLES = 100,
  parameter int RX_TIMEOUT = 20000
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                seq_start,
  input  uart_cmd_pkg::cmd_t  seq_cmd,
  output logic                seq_busy,
  output logic                seq_done,
  output uart_cmd_pkg::byte_t seq_rd_data,
  output logic                seq_rd_err,
  output logic                tx_start,
  output uart_cmd_pkg::byte_t tx_byte,
  input  logic                tx_busy,
  output logic                rx_listen,
  input  logic                rx_frame_vld,
  input  uart_cmd_pkg::byte_t rx_frame_data,
  input  logic                rx_frame_err
);

  localparam int CNT_MAX  = (GAP_CYCLES > RX_TIMEOUT) ? GAP_CYCLES : RX_TIMEOUT;
  localparam int CNT_W    = $clog2(CNT_MAX + 1);
  // the cycle that sees the line idle and the tx_start cycle are part of the gap.
  localparam int GAP_LAST = GAP_CYCLES - 3;

  typedef enum logic [2:0] {
    S_IDLE,
    S_SEND_LO,
    S_GAP,
    S_SEND_HI,
    S_LISTEN,
    S_DONE
  } state_t;

  state_t             state;
  uart_cmd_pkg::cmd_t cmd_q;
  logic [CNT_W-1:0]   cnt;
  logic               frame_end;
  logic               gap_end;
  logic               is_read;

  assign frame_end = !tx_start && !tx_busy;  // tx_busy rises the cycle after tx_start.
  assign gap_end   = (state == S_GAP) && (cnt == CNT_W'(GAP_LAST));
  assign is_read   = !cmd_q[uart_cmd_pkg::CMD_RW_BIT];
  assign seq_busy  = state != S_IDLE;
  assign seq_done  = state == S_DONE;
  assign rx_listen = state == S_LISTEN;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= S_IDLE;
      cnt        <= '0;
      tx_start   <= 1'b0;
      seq_rd_err <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      case (state)
        S_IDLE:
          if (seq_start)
          begin
            tx_start   <= 1'b1;
            seq_rd_err <= 1'b0;
            state      <= S_SEND_LO;
          end
        S_SEND_LO:
          if (frame_end)
          begin
            cnt   <= '0;
            state <= S_GAP;
          end
        S_GAP:
          if (gap_end)
          begin
            tx_start <= 1'b1;
            state    <= S_SEND_HI;
          end
          else
            cnt <= cnt + 1'b1;
        S_SEND_HI:
          if (frame_end)
          begin
            cnt   <= '0;
            state <= is_read ? S_LISTEN : S_DONE;
          end
        S_LISTEN:
          if (rx_frame_vld)
          begin
            seq_rd_err <= rx_frame_err;
            state      <= S_DONE;
          end
          else if (cnt == CNT_W'(RX_TIMEOUT - 1))
          begin
            seq_rd_err <= 1'b1;              // no reply within the window.
            state      <= S_DONE;
          end
          else
            cnt <= cnt + 1'b1;
        S_DONE:
          state <= S_IDLE;
        default:
          state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == S_IDLE && seq_start)
    begin
      cmd_q   <= seq_cmd;
      tx_byte <= seq_cmd[uart_cmd_pkg::ADDR_LSB-1:0];
    end
    if (gap_end)
      tx_byte <= {cmd_q[uart_cmd_pkg::CMD_RW_BIT],
                  cmd_q[uart_cmd_pkg::ADDR_MSB:uart_cmd_pkg::ADDR_LSB]};
    if (state == S_LISTEN)
      seq_rd_data <= rx_frame_vld ? rx_frame_data : '0; // zero is left on a timeout.
  end

endmodule

//--- verilog/uart_cmd_bridge.sv
module uart_cmd_bridge #(
  parameter  int NUM_PORTS  = 2,
  parameter  int BAUD_DIV   = 434,
  parameter  int GAP_CYCLES = 100,
  parameter  int RX_TIMEOUT = 20000,
  localparam int PORT_W     = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  uart_cmd_pkg::cmd_t   cmd [NUM_PORTS],
  input  logic [NUM_PORTS-1:0] cmd_vld,
  output logic [NUM_PORTS-1:0] cmd_rdy,
  output logic [NUM_PORTS-1:0] read_vld,
  output logic [NUM_PORTS-1:0] read_err,
  output uart_cmd_pkg::byte_t  read_data [NUM_PORTS],
  input  logic                 rx,
  output logic                 tx
);

  logic                seq_start;
  uart_cmd_pkg::cmd_t  seq_cmd;
  logic [PORT_W-1:0]   seq_port;
  logic                seq_busy;
  logic                seq_done;
  uart_cmd_pkg::byte_t seq_rd_data;
  logic                seq_rd_err;
  logic                tx_start;
  uart_cmd_pkg::byte_t tx_byte;
  logic                tx_busy;
  logic                rx_listen;
  logic                rx_frame_vld;
  uart_cmd_pkg::byte_t rx_frame_data;
  logic                rx_frame_err;

  cmd_arbiter #(
    .NUM_PORTS (NUM_PORTS)
  ) i_cmd_arbiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .cmd_vld     (cmd_vld),
    .cmd_rdy     (cmd_rdy),
    .read_vld    (read_vld),
    .read_data   (read_data),
    .read_err    (read_err),
    .seq_busy    (seq_busy),
    .seq_done    (seq_done),
    .seq_rd_data (seq_rd_data),
    .seq_rd_err  (seq_rd_err),
    .seq_start   (seq_start),
    .seq_cmd     (seq_cmd),
    .seq_port    (seq_port)
  );

  cmd_sequencer #(
    .GAP_CYCLES (GAP_CYCLES),
    .RX_TIMEOUT (RX_TIMEOUT)
  ) i_cmd_sequencer (
    .clk           (clk),
    .rst_n         (rst_n),
    .seq_start     (seq_start),
    .seq_cmd       (seq_cmd),
    .seq_busy      (seq_busy),
    .seq_done      (seq_done),
    .seq_rd_data   (seq_rd_data),
    .seq_rd_err    (seq_rd_err),
    .tx_start      (tx_start),
    .tx_byte       (tx_byte),
    .tx_busy       (tx_busy),
    .rx_listen     (rx_listen),
    .rx_frame_vld  (rx_frame_vld),
    .rx_frame_data (rx_frame_data),
    .rx_frame_err  (rx_frame_err)
  );

  uart_tx_frame #(
    .BAUD_DIV (BAUD_DIV)
  ) i_uart_tx_frame (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_busy  (tx_busy),
    .tx       (tx)
  );

  uart_rx_frame #(
    .BAUD_DIV (BAUD_DIV)
  ) i_uart_rx_frame (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx            (rx),
    .rx_listen     (rx_listen),
    .rx_frame_vld  (rx_frame_vld),
    .rx_frame_data (rx_frame_data),
    .rx_frame_err  (rx_frame_err)
  );

endmodule

//--- verilog/uart_cmd_pkg.sv
package uart_cmd_pkg;

  // command word: direction, register address, write data.
  typedef logic [15:0] cmd_t;
  typedef logic [7:0]  byte_t;

  localparam int CMD_RW_BIT = 15; // 1 is a write, 0 is a read.
  localparam int ADDR_MSB   = 14;
  localparam int ADDR_LSB   = 8;

  // one frame is start, eight data bits, odd parity and one stop bit.
  localparam int FRAME_BITS = 11;
  localparam int START_BIT  = 0;
  localparam int PAR_BIT    = 9;
  localparam int STOP_BIT   = 10;

endpackage

//--- verilog/uart_rx_frame.sv
module uart_rx_frame #(
  parameter int BAUD_DIV = 434
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                rx,
  input  logic                rx_listen,
  output logic                rx_frame_vld,
  output uart_cmd_pkg::byte_t rx_frame_data,
  output logic                rx_frame_err
);

  localparam int BAUD_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
  localparam int BIT_W  = $clog2(uart_cmd_pkg::FRAME_BITS);
  localparam int HALF   = BAUD_DIV / 2;

  logic [2:0]        rx_sync;
  logic              rx_bit;
  logic              fall;
  logic              busy;
  logic [BAUD_W-1:0] baud_cnt;
  logic [BIT_W-1:0]  bit_idx;
  logic              baud_tick;
  logic              mid;
  logic              data_bit;
  logic              par_err;

  assign rx_bit    = rx_sync[1];
  assign fall      = rx_sync[2:1] == 2'b10;
  assign baud_tick = baud_cnt == BAUD_W'(BAUD_DIV - 1);
  assign mid       = busy && (baud_cnt == BAUD_W'(HALF));
  assign data_bit  = (bit_idx > BIT_W'(uart_cmd_pkg::START_BIT)) &&
                     (bit_idx < BIT_W'(uart_cmd_pkg::PAR_BIT));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_sync      <= '1;
      busy         <= 1'b0;
      baud_cnt     <= '0;
      bit_idx      <= '0;
      par_err      <= 1'b0;
      rx_frame_vld <= 1'b0;
      rx_frame_err <= 1'b0;
    end
    else
    begin
      rx_sync      <= {rx_sync[1:0], rx};
      rx_frame_vld <= 1'b0;
      if (!rx_listen)
        busy <= 1'b0;                       // a frame cut off by the sequencer is dropped.
      else if (!busy)
      begin
        if (fall)
        begin
          busy     <= 1'b1;
          baud_cnt <= BAUD_W'(1);           // the edge cycle counts as the first one.
          bit_idx  <= '0;
        end
      end
      else
      begin
        baud_cnt <= baud_tick ? '0 : baud_cnt + 1'b1;
        if (baud_tick)
          bit_idx <= bit_idx + 1'b1;
        if (mid)
        begin
          if (bit_idx == BIT_W'(uart_cmd_pkg::START_BIT) && rx_bit)
            busy <= 1'b0;                   // line went high again, so it was a glitch.
          else if (bit_idx == BIT_W'(uart_cmd_pkg::PAR_BIT))
            par_err <= ~^{rx_frame_data, rx_bit};
          else if (bit_idx == BIT_W'(uart_cmd_pkg::STOP_BIT))
          begin
            rx_frame_vld <= 1'b1;
            rx_frame_err <= par_err | ~rx_bit;
            busy         <= 1'b0;
          end
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (mid && data_bit)
      rx_frame_data <= {rx_bit, rx_frame_data[7:1]}; // LSB arrives first.
  end

endmodule

//--- verilog/uart_tx_frame.sv
module uart_tx_frame #(
  parameter int BAUD_DIV = 434
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                tx_start,
  input  uart_cmd_pkg::byte_t tx_byte,
  output logic                tx_busy,
  output logic                tx
);

  localparam int BAUD_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
  localparam int BIT_W  = $clog2(uart_cmd_pkg::FRAME_BITS);

  logic [uart_cmd_pkg::FRAME_BITS-1:0] shreg;
  logic [BAUD_W-1:0]                   baud_cnt;
  logic [BIT_W-1:0]                    bit_cnt;
  logic                                baud_tick;

  assign baud_tick = baud_cnt == BAUD_W'(BAUD_DIV - 1);
  assign tx        = shreg[0];              // idle shift register holds all ones.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shreg    <= '1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx_busy  <= 1'b0;
    end
    else if (tx_start && !tx_busy)
    begin
      // stop, odd parity, data LSB first, start.
      shreg    <= {1'b1, ~^tx_byte, tx_byte, 1'b0};
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx_busy  <= 1'b1;
    end
    else if (tx_busy)
    begin
      if (baud_tick)
      begin
        baud_cnt <= '0;
        shreg    <= {1'b1, shreg[uart_cmd_pkg::FRAME_BITS-1:1]};
        bit_cnt  <= bit_cnt + 1'b1;
        if (bit_cnt == BIT_W'(uart_cmd_pkg::FRAME_BITS - 1))
          tx_busy <= 1'b0;                  // last clock of the stop bit.
      end
      else
        baud_cnt <= baud_cnt + 1'b1;
    end
  end

endmodule
